// ==== Bender.yml ====
package:
  name: vec_length

sources:
  - verilog/vec_length_pkg.sv
  - verilog/square_sum.sv
  - verilog/pending_fifo.sv
  - verilog/newton_datapath.sv
  - verilog/step_counter.sv
  - verilog/length_fsm.sv
  - verilog/vec_length_top.sv
  - target: test
    files:
      - tests/vec_length_checker.sv
      - tests/vec_length_tb.sv

// ==== compile.f ====
verilog/vec_length_pkg.sv
verilog/square_sum.sv
verilog/pending_fifo.sv
verilog/newton_datapath.sv
verilog/step_counter.sv
verilog/length_fsm.sv
verilog/vec_length_top.sv
tests/vec_length_checker.sv
tests/vec_length_tb.sv

// ==== tests/vec_length_checker.sv ====
module vec_length_checker #(
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic credit_return,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int occupancy;
    int assert_failures = 0;

    // Shadow count of pending FIFO entries
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    // ------------------------------
    // Handshake rules
    // ------------------------------
    out_valid_single: assert property (@(posedge clk) disable iff (!rst)
        out_valid |=> !out_valid)
        else begin
            assert_failures++;
            $error("out_valid high in two cycles in a row");
        end

    credit_after_pop: assert property (@(posedge clk) disable iff (!rst)
        credit_return |-> $past(pop))
        else begin
            assert_failures++;
            $error("credit_return with no pop in the cycle before");
        end

    // A full FIFO only takes a push when its head leaves in the same cycle
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst)
        (push && occupancy >= FIFO_DEPTH) |-> pop)
        else begin
            assert_failures++;
            $error("push into a full FIFO");
        end

endmodule

// ==== tests/vec_length_tb.sv ====
module vec_length_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    fifo_depth   = 4;
    localparam int    newton_steps = 3;
    localparam string test_file    = "tests/vec_length_tests.txt";

    logic                  clk;
    logic                  rst;
    vec_length_pkg::vec3_t vec;
    logic                  in_valid;
    logic                  credit_return;
    vec_length_pkg::word_t length;
    logic                  out_valid;

    // Cases from the file, and lengths still owed by the DUT in send order
    vec_length_pkg::vec3_t case_vec [$];
    vec_length_pkg::word_t case_len [$];
    vec_length_pkg::word_t expected_q [$];

    int credits      = fifo_depth;
    int sends        = 0;
    int results_seen = 0;
    int errors       = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    vec_length_top #(
        .FIFO_DEPTH   (fifo_depth),
        .NEWTON_STEPS (newton_steps)
    ) vec_length_top_i (
        .clk           (clk),
        .rst           (rst),
        .vec           (vec),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .length        (length),
        .out_valid     (out_valid)
    );

    bind vec_length_top vec_length_checker #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) checker_i (
        .clk           (clk),
        .rst           (rst),
        .push          (sum_valid),
        .pop           (pop),
        .credit_return (credit_return),
        .out_valid     (out_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d results seen",
                     cycle_count, results_seen, sends);
            $display("Done: %0d errors before the timeout", errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_length(input vec_length_pkg::word_t got,
                                input vec_length_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] length got 0x%08h expected 0x%08h (result %0d)",
                     got, exp, results_seen);
        end
    endtask

    task automatic check_credits(input int got, input int exp);
        if (got < exp) begin
            errors++;
            $display("Only %0d of %0d credits came back by the end", got, exp);
        end else if (got > exp) begin
            errors++;
            $display("Sender holds %0d credits, more than the %0d it started with", got, exp);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic load_cases();
        int                    fd;
        int                    fields;
        string                 line;
        vec_length_pkg::word_t wx;
        vec_length_pkg::word_t wy;
        vec_length_pkg::word_t wz;
        vec_length_pkg::word_t len;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open %s", test_file);
            return;
        end
        // Comment lines do not parse as four hex words and drop out here
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h", wx, wy, wz, len);
            if (fields == 4) begin
                case_vec.push_back('{x: wx, y: wy, z: wz});
                case_len.push_back(len);
            end
        end
        $fclose(fd);
    endtask

    task automatic collect_outputs();
        if (credit_return) begin
            credits++;
        end
        if (out_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("A result came out with no vector waiting for it");
            end else begin
                check_length(length, expected_q.pop_front());
            end
            results_seen++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        collect_outputs();
    endtask

    // One vector per call, spending a credit
    task automatic send_case(input int idx, input bit with_gap);
        int gap;
        gap = with_gap ? int'($urandom % 12) : 0;
        next_cycle();
        repeat (gap) next_cycle();
        while (credits == 0) next_cycle();
        vec      = case_vec[idx];
        in_valid = 1'b1;
        credits--;
        sends++;
        expected_q.push_back(case_len[idx]);
    endtask

    initial begin
        int assert_fails;
        vec      = '0;
        in_valid = 1'b0;
        rst      = 1'b0;
        void'($urandom(32'h1ff3_7065));
        load_cases();
        cycle_limit = 2 * case_vec.size() * (newton_steps + 6) * 4 + 200;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        if (case_vec.size() == 0) begin
            errors++;
            $display("No test cases were loaded");
        end else begin
            // Back to back first, so the burst drains every credit
            for (int i = 0; i < case_vec.size(); i++) begin
                send_case(i, 1'b0);
            end
            for (int i = 0; i < case_vec.size(); i++) begin
                send_case(i, 1'b1);
            end
            while (results_seen < sends) next_cycle();
            repeat (4) next_cycle();
        end
        check_credits(credits, fifo_depth);
        assert_fails = vec_length_top_i.checker_i.assert_failures;
        if (assert_fails > 0) begin
            errors += assert_fails;
            $display("%0d assertion failures in the bound checker", assert_fails);
        end
        $display("Done: %0d vectors sent, %0d results checked, %0d errors",
                 sends, results_seen, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/vec_length_tests.txt ====
# x y z expected_length, each a hex Q16.16 word
# lengths follow the leading-one seed and three truncating Newton steps
00010000 00000000 00000000 00010000
00000000 00010000 00000000 00010000
00000000 00000000 00010000 00010000
ffff0000 00000000 00000000 00010000
00020000 00000000 00000000 00020000
00000000 fffe0000 00000000 00020000
00000000 00000000 00020000 00020000
00030000 00040000 00000000 0004ffb0
fffd0000 00000000 fffc0000 0004ffb0
00000000 00040000 00030000 0004ffb0
00000000 00000000 00030000 0002c05b
00010000 00020000 00020000 0002c05b
00020000 00010000 00020000 0002c05b
00008000 00000000 00000000 00008000
ffff8000 00000000 00000000 00008000
00000000 00004000 00000000 00004000
00000000 00000000 ffffc000 00004000
00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000
01000000 00000000 00000000 00c7ffff
ff000000 00000000 00000000 00c7ffff
00c80000 00c80000 00000000 00c7ffff

// ==== verilog/length_fsm.sv ====
module length_fsm (
    input  logic clk,
    input  logic rst,
    input  logic not_empty,
    input  logic count_done,
    output logic pop,
    output logic load,
    output logic step,
    output logic scale,
    output logic out_valid
);

    vec_length_pkg::len_state_t state;
    vec_length_pkg::len_state_t state_next;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= vec_length_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            vec_length_pkg::IDLE: begin
                if (not_empty) begin
                    state_next = vec_length_pkg::SEED;
                end
            end
            vec_length_pkg::SEED:    state_next = vec_length_pkg::ITERATE;
            vec_length_pkg::ITERATE: begin
                if (count_done) begin
                    state_next = vec_length_pkg::SCALE;
                end
            end
            vec_length_pkg::SCALE:   state_next = vec_length_pkg::EMIT;
            vec_length_pkg::EMIT:    state_next = vec_length_pkg::IDLE;
            default:                 state_next = vec_length_pkg::IDLE;
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    // Head is popped and captured in the same cycle
    assign pop       = (state == vec_length_pkg::IDLE) && not_empty;
    assign load      = pop;
    assign step      = (state == vec_length_pkg::ITERATE);
    assign scale     = (state == vec_length_pkg::SCALE);
    assign out_valid = (state == vec_length_pkg::EMIT);

endmodule

// ==== verilog/newton_datapath.sv ====
module newton_datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  vec_length_pkg::word_t head,
    input  logic                  step,
    input  logic                  scale,
    output vec_length_pkg::word_t length
);

    localparam vec_length_pkg::word_t three = 3 <<< vec_length_pkg::frac_bits;
    localparam vec_length_pkg::word_t half  = 1 <<< (vec_length_pkg::frac_bits - 1);

    vec_length_pkg::word_t sum_q;
    vec_length_pkg::word_t est;
    vec_length_pkg::word_t seed;
    vec_length_pkg::word_t est_next;
    logic                  seed_pending;
    int                    msb;
    int                    lead_pos;
    int                    seed_shift;

    // ------------------------------
    // Seed from leading one
    // ------------------------------

    // Estimate 2^-floor(p/2) where p is the leading-one position past the binary point
    always_comb begin
        msb = 0;
        for (int i = 0; i < vec_length_pkg::word_width; i++) begin
            if (sum_q[i]) begin
                msb = i;
            end
        end
        lead_pos   = msb - vec_length_pkg::frac_bits;
        seed_shift = vec_length_pkg::frac_bits - (lead_pos >>> 1);
        seed       = '0;
        seed[seed_shift] = 1'b1;
    end

    // ------------------------------
    // Newton step
    // ------------------------------

    // y' = y * (3 - s*y^2) / 2 with the halving done through fp_mul
    assign est_next = vec_length_pkg::fp_mul(
        vec_length_pkg::fp_mul(est, three - vec_length_pkg::fp_mul(
            sum_q, vec_length_pkg::fp_mul(est, est))),
        half);

    // Seed is written in the cycle after the sum is captured
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seed_pending <= 1'b0;
        end else begin
            seed_pending <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sum_q <= head;
        end
        if (seed_pending) begin
            est <= seed;
        end else if (step) begin
            est <= est_next;
        end
        // Zero has no leading one, so its length is forced
        if (scale) begin
            length <= (sum_q == '0) ? '0 : vec_length_pkg::fp_mul(sum_q, est);
        end
    end

endmodule

// ==== verilog/pending_fifo.sv ====
module pending_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  vec_length_pkg::word_t din,
    input  logic                  pop,
    output vec_length_pkg::word_t head,
    output logic                  not_empty,
    output logic                  credit_return
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    vec_length_pkg::word_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // A full FIFO still takes a push when the head leaves in the same cycle
    assign wr_en = push && (!full || pop);
    assign rd_en = pop && not_empty;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            // One credit back per released slot
            credit_return <= rd_en;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== verilog/square_sum.sv ====
module square_sum (
    input  logic                  clk,
    input  logic                  rst,
    input  vec_length_pkg::vec3_t vec,
    input  logic                  in_valid,
    output vec_length_pkg::word_t sum,
    output logic                  sum_valid
);

    // ------------------------------
    // Sum of squares stage
    // ------------------------------

    // Valid follows in_valid one cycle later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= in_valid;
        end
    end

    // Only captured with a valid vector, so the FIFO sees a stable word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum <= vec_length_pkg::sq_sum(vec);
        end
    end

endmodule

// ==== verilog/step_counter.sv ====
module step_counter #(
    parameter int NEWTON_STEPS = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic count_done
);

    localparam int CNT_W = $clog2(NEWTON_STEPS + 1);

    logic [CNT_W-1:0] count;

    // Flags the last step too, so ITERATE lasts exactly NEWTON_STEPS cycles
    assign count_done = (count <= CNT_W'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(NEWTON_STEPS);
        end else if (step && count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== verilog/vec_length_pkg.sv ====
package vec_length_pkg;

    // ------------------------------
    // Word format
    // ------------------------------
    parameter int word_width = 32;
    parameter int frac_bits  = 16;

    // Signed Q16.16
    typedef logic signed [word_width-1:0] word_t;

    typedef struct packed {
        word_t x;
        word_t y;
        word_t z;
    } vec3_t;

    typedef enum logic [2:0] {
        IDLE,
        SEED,
        ITERATE,
        SCALE,
        EMIT
    } len_state_t;

    parameter word_t word_max = {1'b0, {(word_width-1){1'b1}}};
    parameter word_t word_min = {1'b1, {(word_width-1){1'b0}}};

    // ------------------------------
    // Fixed-point helpers
    // ------------------------------

    // Q16.16 product rounded toward zero and clamped to the word range
    function automatic word_t fp_mul(input word_t a, input word_t b);
        logic signed [2*word_width-1:0] prod;
        logic signed [2*word_width-1:0] shifted;
        prod = a * b;
        if (prod < 0) begin
            prod = prod + ((2 * word_width)'(1) << frac_bits) - 1;
        end
        shifted = prod >>> frac_bits;
        if (shifted > word_max) begin
            return word_max;
        end else if (shifted < word_min) begin
            return word_min;
        end
        return word_t'(shifted);
    endfunction

    // Squares are never negative, so only the top end needs clamping
    function automatic word_t sq_sum(input vec3_t v);
        logic [word_width+1:0] acc;
        acc = {2'b00, fp_mul(v.x, v.x)} + {2'b00, fp_mul(v.y, v.y)}
            + {2'b00, fp_mul(v.z, v.z)};
        if (acc > {2'b00, word_max}) begin
            return word_max;
        end
        return word_t'(acc);
    endfunction

endpackage

// ==== verilog/vec_length_top.sv ====
module vec_length_top #(
    parameter int FIFO_DEPTH   = 4,
    parameter int NEWTON_STEPS = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  vec_length_pkg::vec3_t vec,
    input  logic                  in_valid,
    output logic                  credit_return,
    output vec_length_pkg::word_t length,
    output logic                  out_valid
);

    vec_length_pkg::word_t sum;
    vec_length_pkg::word_t head;
    logic                  sum_valid;
    logic                  not_empty;
    logic                  pop;
    logic                  load;
    logic                  step;
    logic                  scale;
    logic                  count_done;

    // ------------------------------
    // Front end
    // ------------------------------
    square_sum square_sum_i (
        .clk       (clk),
        .rst       (rst),
        .vec       (vec),
        .in_valid  (in_valid),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    pending_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pending_fifo_i (
        .clk           (clk),
        .rst           (rst),
        .push          (sum_valid),
        .din           (sum),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    // ------------------------------
    // Inverse square root engine
    // ------------------------------
    length_fsm length_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .not_empty  (not_empty),
        .count_done (count_done),
        .pop        (pop),
        .load       (load),
        .step       (step),
        .scale      (scale),
        .out_valid  (out_valid)
    );

    step_counter #(
        .NEWTON_STEPS (NEWTON_STEPS)
    ) step_counter_i (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .count_done (count_done)
    );

    newton_datapath newton_datapath_i (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .head   (head),
        .step   (step),
        .scale  (scale),
        .length (length)
    );

endmodule
